/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in its output
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal -f vmul_unit.f --top-module tb_vmul_unit \
       -o tb_vmul_unit \
  && ./obj_dir/tb_vmul_unit | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb_vmul_checker.sv */
////////////////////
// scoreboard for the vector multiply unit
// expects every accepted micro-op back exactly one cycle later, in order
// outputs are sampled on the rising edge, stimulus must change by NBA
////////////////////

module tb_vmul_checker
  import vmul_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  in_valid,
  input  logic [ROB_TAG_W-1:0]  rob_entry,
  input  logic [5:0]            funct6,
  input  logic [2:0]            funct3,
  input  logic [1:0]            vxrm,
  input  logic [1:0]            eew,
  input  logic [VLEN-1:0]       vs1_data,
  input  logic                  vs1_valid,
  input  logic [VLEN-1:0]       vs2_data,
  input  logic                  vs2_valid,
  input  logic [XLEN-1:0]       rs1_data,
  input  logic                  rs1_valid,
  input  logic                  out_valid,
  input  logic [ROB_TAG_W-1:0]  out_rob_entry,
  input  logic [VLEN-1:0]       out_data,
  input  logic [VLENB-1:0]      out_vsat,
  output int                    value_errors,
  output int                    protocol_errors,
  output int                    compared,
  output int                    pending
);

  int                     cycle;
  logic                   seen_uop;
  logic [ROB_TAG_W-1:0]   tag_q[$];
  logic [VLENB+VLEN-1:0]  exp_q[$];     // {vsat, data}
  int                     cyc_q[$];
  string                  name_q[$];

  // 0 vmul, 1 vmulh, 2 vmulhu, 3 vmulhsu, 4 vsmul, -1 no multiply
  function automatic int op_kind(input logic [5:0] f6, input logic [2:0] f3);
    if (f3 == OPIVV || f3 == OPIVX) return 4;
    if (f3 != OPMVV && f3 != OPMVX) return -1;
    case (f6)
      VMULH:   return 1;
      VMULHU:  return 2;
      VMULHSU: return 3;
      default: return 0;
    endcase
  endfunction

  function automatic string uop_name(input int kind, input logic [1:0] ew, input logic [2:0] f3);
    string base;
    case (kind)
      0:       base = "vmul";
      1:       base = "vmulh";
      2:       base = "vmulhu";
      3:       base = "vmulhsu";
      4:       base = "vsmul";
      default: base = "no-op funct3";
    endcase
    return $sformatf("%s.%s e%0d", base, f3[2] ? "vx" : "vv",
                     (ew == EEW16) ? 16 : ((ew == EEW32) ? 32 : 8));
  endfunction

  function automatic logic [31:0] lane_get(input lane_word_t v, input int nb, input int e);
    case (nb)
      1:       return {24'b0, v.b[e]};
      2:       return {16'b0, v.h[e]};
      default: return v.w[e];
    endcase
  endfunction

  // one element from the arithmetic definition, returns {sat, result}
  function automatic logic [32:0] elem_ref(input logic [31:0] a, input logic [31:0] b,
                                           input int nb, input int kind, input logic [1:0] xrm);
    int                 w;
    logic signed [65:0] ea;
    logic signed [65:0] eb;
    logic signed [65:0] p;
    logic signed [65:0] q;
    logic signed [65:0] max_pos;
    logic [65:0]        pu;
    logic [31:0]        wmask;
    logic               incr;
    w     = 8 * nb;
    wmask = (nb == 4) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
    ea    = $signed({34'b0, a & wmask});
    eb    = $signed({34'b0, b & wmask});
    if ((kind == 1 || kind == 3 || kind == 4) && a[w-1]) ea = ea - (66'sd1 <<< w);
    if ((kind == 1 || kind == 4) && b[w-1]) eb = eb - (66'sd1 <<< w);
    p  = ea * eb;
    pu = p;
    if (kind == 0) return {1'b0, pu[31:0] & wmask};
    if (kind != 4) return {1'b0, 32'(pu >> w) & wmask};
    case (xrm)                        // rounding increment on the dropped bits
      RNU:     incr = pu[w-2];
      RNE:     incr = pu[w-2] & ((|(pu & ((66'd1 << (w - 2)) - 66'd1))) | pu[w-1]);
      RDN:     incr = 1'b0;
      default: incr = ~pu[w-1] & (|(pu & ((66'd1 << (w - 1)) - 66'd1)));
    endcase
    q       = (p >>> (w - 1)) + $signed({65'b0, incr});
    max_pos = (66'sd1 <<< (w - 1)) - 66'sd1;
    if (q > max_pos) return {1'b1, 32'(max_pos)};
    return {1'b0, 32'(q) & wmask};
  endfunction

  function automatic logic [VLENB+VLEN-1:0] expect_uop(
      input logic [5:0] f6, input logic [2:0] f3, input logic [1:0] ew, input logic [1:0] xrm,
      input lane_word_t v1, input lane_word_t v2, input logic [XLEN-1:0] x1);
    int               nb;
    int               kind;
    logic [31:0]      b;
    logic [32:0]      r;
    lane_word_t       res;
    logic [VLENB-1:0] sat;
    nb   = (ew == EEW16) ? 2 : ((ew == EEW32) ? 4 : 1);
    kind = op_kind(f6, f3);
    res  = '0;
    sat  = '0;
    if (kind < 0) return '0;
    for (int e = 0; e < VLENB / nb; e++) begin
      b = f3[2] ? x1 : lane_get(v1, nb, e);       // scalar forms reuse rs1
      r = elem_ref(lane_get(v2, nb, e), b, nb, kind, xrm);
      case (nb)
        1:       res.b[e] = r[7:0];
        2:       res.h[e] = r[15:0];
        default: res.w[e] = r[31:0];
      endcase
      sat[e*nb + nb - 1] = r[32];
    end
    return {sat, res};
  endfunction

  ////////////////////
  // compare process
  ////////////////////
  always @(posedge clk or negedge arst_n) begin
    logic [VLENB+VLEN-1:0] exp;
    if (!arst_n) begin
      cycle = 0;
      seen_uop = 1'b0;
      value_errors = 0;
      protocol_errors = 0;
      compared = 0;
      tag_q.delete();
      exp_q.delete();
      cyc_q.delete();
      name_q.delete();
    end else begin
      cycle = cycle + 1;
      if (out_valid && tag_q.size() == 0) begin
        $display("out_valid arrived at cycle %0d with no micro-op waiting for it", cycle);
        protocol_errors++;
      end else if (out_valid) begin
        exp = exp_q.pop_front();
        if (cyc_q[0] + 1 != cycle) begin
          $display("out_valid arrived at cycle %0d, its in_valid was at cycle %0d",
                   cycle, cyc_q[0]);
          protocol_errors++;
        end
        if (out_rob_entry != tag_q[0]) begin
          $display("** Error [%s] tag expected %h actual %h", name_q[0], tag_q[0],
                   out_rob_entry);
          value_errors++;
        end
        if (out_data != exp[VLEN-1:0]) begin
          $display("** Error [%s] data expected %h actual %h", name_q[0], exp[VLEN-1:0],
                   out_data);
          value_errors++;
        end
        if (out_vsat != exp[VLENB+VLEN-1:VLEN]) begin
          $display("** Error [%s] vsat expected %h actual %h", name_q[0],
                   exp[VLENB+VLEN-1:VLEN], out_vsat);
          value_errors++;
        end
        void'(tag_q.pop_front());
        void'(cyc_q.pop_front());
        void'(name_q.pop_front());
        compared++;
      end else if (tag_q.size() != 0 && cyc_q[0] < cycle) begin
        $display("no out_valid one cycle after the in_valid of cycle %0d", cyc_q[0]);
        protocol_errors++;
        void'(exp_q.pop_front());
        void'(tag_q.pop_front());
        void'(cyc_q.pop_front());
        void'(name_q.pop_front());
      end else if (!seen_uop && {out_rob_entry, out_vsat, out_data} != '0) begin
        $display("** Error [reset] outputs expected 0 actual %h",
                 {out_rob_entry, out_vsat, out_data});
        value_errors++;
      end
      if (in_valid) begin                       // micro-op taken on this edge
        seen_uop = 1'b1;
        exp_q.push_back(expect_uop(funct6, funct3, eew, vxrm,
                                   vs1_valid ? vs1_data : '0, vs2_valid ? vs2_data : '0,
                                   rs1_valid ? rs1_data : '0));
        tag_q.push_back(rob_entry);
        cyc_q.push_back(cycle);
        name_q.push_back(uop_name(op_kind(funct6, funct3), eew, funct3));
      end
      pending = tag_q.size();
    end
  end

endmodule

/* tb_vmul_unit.sv */
////////////////////
// testbench top for the vector multiply unit
// stimulus from a 32-bit Galois LFSR with a fixed seed, checks live in tb_vmul_checker
////////////////////

module tb_vmul_unit;
  import vmul_pkg::*;

  logic                  clk;
  logic                  arst_n;
  logic                  in_valid;
  logic [ROB_TAG_W-1:0]  rob_entry;
  logic [5:0]            funct6;
  logic [2:0]            funct3;
  logic [1:0]            vxrm;
  logic [1:0]            eew;
  logic [VLEN-1:0]       vs1_data;
  logic                  vs1_valid;
  logic [VLEN-1:0]       vs2_data;
  logic                  vs2_valid;
  logic [XLEN-1:0]       rs1_data;
  logic                  rs1_valid;
  logic                  out_valid;
  logic [ROB_TAG_W-1:0]  out_rob_entry;
  logic [VLEN-1:0]       out_data;
  logic [VLENB-1:0]      out_vsat;
  int                    value_errors;
  int                    protocol_errors;
  int                    compared;
  int                    pending;
  int                    issued;
  int                    other_errors;
  logic [31:0]           lfsr;

  always #5 clk = ~clk;

  vmul_unit u_dut (.*);

  tb_vmul_checker u_check (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[126:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic logic [5:0] mul_code(input int k);
    case (k)
      0:       return VMUL;
      1:       return VMULH;
      2:       return VMULHU;
      3:       return VMULHSU;
      4:       return 6'b000001;            // not an OPM multiply
      default: return 6'(rand_bits(6));
    endcase
  endfunction

  // element e becomes the most negative value of its width
  function automatic logic [VLEN-1:0] set_min(input lane_word_t v, input int nb, input int e);
    case (nb)
      1:       v.b[e] = 8'h80;
      2:       v.h[e] = 16'h8000;
      default: v.w[e] = 32'h8000_0000;
    endcase
    return v;
  endfunction

  task automatic send_uop(input logic [5:0] f6, input logic [2:0] f3, input logic [1:0] xrm,
                          input logic [1:0] ew, input logic [VLEN-1:0] v1,
                          input logic [VLEN-1:0] v2, input logic [XLEN-1:0] x1,
                          input logic [2:0] valids);
    @(posedge clk);
    in_valid  <= 1'b1;
    rob_entry <= issued[ROB_TAG_W-1:0];
    funct6    <= f6;
    funct3    <= f3;
    vxrm      <= xrm;
    eew       <= ew;
    vs1_data  <= v1;
    vs2_data  <= v2;
    rs1_data  <= x1;
    vs1_valid <= valids[2];
    vs2_valid <= valids[1];
    rs1_valid <= valids[0];
    issued++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  initial begin
    lane_word_t a;
    lane_word_t b;
    int         nb;
    int         wait_cnt;
    clk          = 1'b0;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    rob_entry    = '0;
    funct6       = '0;
    funct3       = '0;
    vxrm         = '0;
    eew          = '0;
    vs1_data     = '0;
    vs1_valid    = 1'b0;
    vs2_data     = '0;
    vs2_valid    = 1'b0;
    rs1_data     = '0;
    rs1_valid    = 1'b0;
    issued       = 0;
    other_errors = 0;
    lfsr         = 32'd83681;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    idle_cycles(4);                             // reset values stay put

    ////////////////////
    // plain multiply, then vsmul per rounding mode
    ////////////////////
    for (int k = 0; k < 4; k++)
      for (int ew = 0; ew < 3; ew++)
        for (int n = 0; n < 6; n++)            // even n vector, odd n scalar
          send_uop(mul_code(k), n[0] ? OPMVX : OPMVV, 2'(rand_bits(2)), 2'(ew),
                   rand_bits(128), rand_bits(128), 32'(rand_bits(32)), 3'b111);
    idle_cycles(2);
    for (int xrm = 0; xrm < 4; xrm++)
      for (int ew = 0; ew < 3; ew++)
        for (int n = 0; n < 6; n++)
          send_uop(VSMUL, n[0] ? OPIVX : OPIVV, 2'(xrm), 2'(ew),
                   rand_bits(128), rand_bits(128), 32'(rand_bits(32)), 3'b111);
    idle_cycles(2);

    // saturation on min x min, neighbours random
    for (int ew = 0; ew < 3; ew++) begin
      nb = (ew == 0) ? 1 : 2 * ew;
      a  = set_min(rand_bits(128), nb, 0);
      b  = set_min(set_min(rand_bits(128), nb, 0), nb, 2);
      send_uop(VSMUL, OPIVV, 2'(rand_bits(2)), 2'(ew), a, b, '0, 3'b111);
      send_uop(VSMUL, OPIVX, 2'(rand_bits(2)), 2'(ew), '0, b,
               32'd1 << (8 * nb - 1), 3'b111);
    end
    idle_cycles(2);

    ////////////////////
    // defaults and back-to-back random micro-ops
    ////////////////////
    send_uop(6'b000000, OPMVV, RNU, EEW16, rand_bits(128), rand_bits(128), '0, 3'b111);
    send_uop(6'b010101, OPIVV, RNE, EEW32, rand_bits(128), rand_bits(128), '0, 3'b111);
    send_uop(VMULH, OPMVV, RNU, 2'd3, rand_bits(128), rand_bits(128), '0, 3'b111);
    send_uop(VMUL, OPMVX, RNU, EEW8, rand_bits(128), rand_bits(128), 32'h5a, 3'b110);
    send_uop(VSMUL, OPIVV, RNU, EEW16, rand_bits(128), rand_bits(128), '0, 3'b001);
    send_uop(VMUL, 3'd1, RNU, EEW8, rand_bits(128), rand_bits(128), '0, 3'b111);
    for (int n = 0; n < 80; n++)
      send_uop(mul_code(int'(rand_bits(3))), 3'(rand_bits(3)), 2'(rand_bits(2)),
               2'(rand_bits(2)), rand_bits(128), rand_bits(128), 32'(rand_bits(32)),
               3'(rand_bits(3) | rand_bits(3)));
    idle_cycles(1);

    // drain with a bound
    wait_cnt = 0;
    do begin
      @(negedge clk);
      wait_cnt++;
    end while (pending != 0 && wait_cnt < 20);
    if (pending != 0) begin
      $display("timed out waiting for %0d results from the DUT", pending);
      other_errors++;
    end
    if (compared != issued) begin
      $display("only %0d of %0d issued micro-ops were compared", compared, issued);
      other_errors++;
    end
    $display("closing: %0d issued, %0d compared, %0d value errors, %0d protocol errors, %0d other",
             issued, compared, value_errors, protocol_errors, other_errors);
    if (value_errors + protocol_errors + other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* vmul_lane_combine.sv */
////////////////////
// combines byte products into element products and picks the result
// vsmul shifts by width minus one, rounds per vxrm and saturates
// saturation mask bit lands on the top byte of the element
////////////////////

module vmul_lane_combine
  import vmul_pkg::*;
(
  input  logic [NUM_MUL8-1:0][15:0]  prod,
  input  logic [1:0]                 eew_q,
  input  logic [1:0]                 vxrm_q,
  input  logic                       src2_signed_q,
  input  logic                       src1_signed_q,
  input  logic                       keep_low_q,
  input  logic                       is_vsmul_q,
  output logic [VLEN-1:0]            out_data,
  output logic [VLENB-1:0]           out_vsat
);

  lane_word_t         res8;
  lane_word_t         res16;
  lane_word_t         res32;
  logic [VLENB-1:0]   sat8;
  logic [VLENB-1:0]   sat16;
  logic [VLENB-1:0]   sat32;

  // full product of one element of nb bytes, base = its low x low product
  // only the low 16*nb bits are meaningful
  function automatic logic [63:0] elem_full(input logic [NUM_MUL8-1:0][15:0] p,
                                            input int base, input int nb,
                                            input logic s2, input logic s1);
    logic [63:0] acc;
    logic [63:0] term;
    logic [15:0] pp;
    acc = '0;
    for (int y = 0; y < 4; y++) begin
      for (int x = 0; x < 4; x++) begin
        if (x < nb && y < nb) begin
          pp = p[base + y*4 + x];
          if ((x == nb - 1 && s2) || (y == nb - 1 && s1))
            term = {{48{pp[15]}}, pp};          // product holds a signed byte
          else
            term = {48'b0, pp};
          acc = acc + (term << (8 * (x + y)));
        end
      end
    end
    return acc;
  endfunction

  // returns {sat, data}, data valid in the low 8*nb bits
  function automatic logic [32:0] elem_result(input logic [63:0] full, input int nb,
                                              input logic keep_low, input logic vsmul,
                                              input logic [1:0] xrm);
    int          w;
    logic [63:0] low_mask;
    logic [63:0] max_pos;
    logic [63:0] data;
    logic        bit_d;
    logic        bit_r;
    logic        lower_any;
    logic        incr;
    logic        sat;
    w         = 8 * nb;
    low_mask  = (64'd1 << (w - 2)) - 64'd1;
    max_pos   = (64'd1 << (w - 1)) - 64'd1;
    bit_d     = full[w-1];            // lsb kept after the shift
    bit_r     = full[w-2];            // first dropped bit
    lower_any = |(full & low_mask);
    incr      = 1'b0;
    case (xrm)
      RNU: incr = bit_r;
      RNE: incr = bit_r & (lower_any | bit_d);
      RDN: incr = 1'b0;
      ROD: incr = ~bit_d & (bit_r | lower_any);
    endcase
    // only min x min reaches 01 in the top two bits
    sat = vsmul && (((full >> (2*w - 2)) & 64'd3) == 64'd1);
    if (!vsmul)
      data = keep_low ? full : (full >> w);
    else if (sat)
      data = max_pos;
    else
      data = (full >> (w - 1)) + {63'b0, incr};
    return {sat, data[31:0]};
  endfunction

  ////////////////////
  // per width results
  ////////////////////
  always_comb begin
    logic [32:0] r;
    sat16 = '0;
    sat32 = '0;
    for (int e = 0; e < VLENB; e++) begin        // diagonal products
      r = elem_result(elem_full(prod, (e / 4)*16 + (e % 4)*5, 1, src2_signed_q,
                                src1_signed_q), 1, keep_low_q, is_vsmul_q, vxrm_q);
      res8.b[e] = r[7:0];
      sat8[e]   = r[32];
    end
    for (int e = 0; e < VLENB / 2; e++) begin    // 4-term sums
      r = elem_result(elem_full(prod, (e / 2)*16 + (e % 2)*10, 2, src2_signed_q,
                                src1_signed_q), 2, keep_low_q, is_vsmul_q, vxrm_q);
      res16.h[e]     = r[15:0];
      sat16[2*e + 1] = r[32];
    end
    for (int e = 0; e < VLENB / 4; e++) begin    // 16-term sums
      r = elem_result(elem_full(prod, e*16, 4, src2_signed_q, src1_signed_q),
                      4, keep_low_q, is_vsmul_q, vxrm_q);
      res32.w[e]     = r[31:0];
      sat32[4*e + 3] = r[32];
    end
  end

  // width select
  always_comb begin
    case (eew_q)
      EEW8: begin
        out_data = res8;
        out_vsat = sat8;
      end
      EEW16: begin
        out_data = res16;
        out_vsat = sat16;
      end
      EEW32: begin
        out_data = res32;
        out_vsat = sat32;
      end
      default: begin                  // eew 3 acts as 8-bit
        out_data = res8;
        out_vsat = sat8;
      end
    endcase
  end

endmodule

/* vmul_operand_decode.sv */
////////////////////
// combinational micro-op decode for the vector multiply unit
// unknown OPM funct6 runs as vmul, unknown OPI funct6 as vsmul
// any other funct3 or an idle cycle yields zero operands
////////////////////

module vmul_operand_decode
  import vmul_pkg::*;
(
  input  logic              in_valid,
  input  logic [5:0]        funct6,
  input  logic [2:0]        funct3,
  input  logic [1:0]        eew,
  input  logic [VLEN-1:0]   vs1_data,
  input  logic              vs1_valid,
  input  logic [VLEN-1:0]   vs2_data,
  input  logic              vs2_valid,
  input  logic [XLEN-1:0]   rs1_data,
  input  logic              rs1_valid,
  output logic [VLEN-1:0]   src2,
  output logic [VLEN-1:0]   src1,
  output logic [VLENB-1:0]  src2_byte_signed,
  output logic [VLENB-1:0]  src1_byte_signed,
  output logic              src2_signed,
  output logic              src1_signed,
  output logic              keep_low,
  output logic              is_vsmul
);

  lane_word_t scalar_rep;             // rs1 copied into every element

  // replicate the low eew bits of rs1
  always_comb begin
    case (eew)
      EEW16: begin
        for (int i = 0; i < VLENB / 2; i++) scalar_rep.h[i] = rs1_data[15:0];
      end
      EEW32: begin
        for (int i = 0; i < VLENB / 4; i++) scalar_rep.w[i] = rs1_data;
      end
      default: begin                  // eew 3 falls back to bytes
        for (int i = 0; i < VLENB; i++) scalar_rep.b[i] = rs1_data[7:0];
      end
    endcase
  end

  ////////////////////
  // operation class
  ////////////////////
  always_comb begin
    src2        = '0;
    src1        = '0;
    src2_signed = 1'b0;
    src1_signed = 1'b0;
    keep_low    = 1'b0;
    is_vsmul    = 1'b0;
    if (in_valid && (funct3 == OPMVV || funct3 == OPMVX)) begin
      src2 = vs2_valid ? vs2_data : '0;
      if (funct3 == OPMVX) src1 = rs1_valid ? scalar_rep : '0;
      else                 src1 = vs1_valid ? vs1_data : '0;
      case (funct6)
        VMULH: begin
          src2_signed = 1'b1;
          src1_signed = 1'b1;
        end
        VMULHU: begin                 // both unsigned, high half
        end
        VMULHSU: src2_signed = 1'b1;
        default: begin                // VMUL and unknown codes
          src2_signed = 1'b1;
          src1_signed = 1'b1;
          keep_low    = 1'b1;
        end
      endcase
    end else if (in_valid && (funct3 == OPIVV || funct3 == OPIVX)) begin
      src2        = vs2_valid ? vs2_data : '0;
      src1        = (funct3 == OPIVX) ? (rs1_valid ? scalar_rep : '0)
                                      : (vs1_valid ? vs1_data : '0);
      src2_signed = 1'b1;
      src1_signed = 1'b1;
      is_vsmul    = 1'b1;             // every OPI funct6 runs as vsmul
    end
  end

  // sign flag sits on the top byte of each element only
  always_comb begin
    case (eew)
      EEW16: begin
        src2_byte_signed = {(VLENB / 2){src2_signed, 1'b0}};
        src1_byte_signed = {(VLENB / 2){src1_signed, 1'b0}};
      end
      EEW32: begin
        src2_byte_signed = {(VLENB / 4){src2_signed, 3'b0}};
        src1_byte_signed = {(VLENB / 4){src1_signed, 3'b0}};
      end
      default: begin
        src2_byte_signed = {VLENB{src2_signed}};
        src1_byte_signed = {VLENB{src1_signed}};
      end
    endcase
  end

endmodule

/* vmul_partial_stage.sv */
////////////////////
// 8x8 multiplier grid and the single pipeline register of the unit
// products and control are captured every cycle, there is no stall
////////////////////

module vmul_partial_stage
  import vmul_pkg::*;
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       in_valid,
  input  logic [ROB_TAG_W-1:0]       rob_entry,
  input  logic [1:0]                 eew,
  input  logic [1:0]                 vxrm,
  input  logic [VLEN-1:0]            src2,
  input  logic [VLEN-1:0]            src1,
  input  logic [VLENB-1:0]           src2_byte_signed,
  input  logic [VLENB-1:0]           src1_byte_signed,
  input  logic                       src2_signed,
  input  logic                       src1_signed,
  input  logic                       keep_low,
  input  logic                       is_vsmul,
  output logic [NUM_MUL8-1:0][15:0]  prod,
  output logic                       valid_q,
  output logic [ROB_TAG_W-1:0]       rob_entry_q,
  output logic [1:0]                 eew_q,
  output logic [1:0]                 vxrm_q,
  output logic                       src2_signed_q,
  output logic                       src1_signed_q,
  output logic                       keep_low_q,
  output logic                       is_vsmul_q
);

  logic [NUM_MUL8-1:0][15:0] prod_d;

  // byte multiply, each side signed or unsigned
  function automatic logic [15:0] mul8(input logic [7:0] a, input logic a_signed,
                                       input logic [7:0] b, input logic b_signed);
    logic signed [8:0]  ea;
    logic signed [8:0]  eb;
    logic signed [17:0] p;
    ea = {a_signed & a[7], a};
    eb = {b_signed & b[7], b};
    p  = ea * eb;
    return p[15:0];                   // result always fits in 16 bits
  endfunction

  // column z covers bytes 4z..4z+3, product index z*16 + y*4 + x
  always_comb begin
    for (int z = 0; z < 4; z++) begin
      for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
          prod_d[z*16 + y*4 + x] = mul8(src2[(z*4 + x)*8 +: 8], src2_byte_signed[z*4 + x],
                                        src1[(z*4 + y)*8 +: 8], src1_byte_signed[z*4 + y]);
        end
      end
    end
  end

  ////////////////////
  // stage register
  ////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod          <= '0;
      valid_q       <= 1'b0;
      rob_entry_q   <= '0;
      eew_q         <= '0;
      vxrm_q        <= '0;
      src2_signed_q <= 1'b0;
      src1_signed_q <= 1'b0;
      keep_low_q    <= 1'b0;
      is_vsmul_q    <= 1'b0;
    end else begin
      prod          <= prod_d;
      valid_q       <= in_valid;
      rob_entry_q   <= rob_entry;
      eew_q         <= eew;
      vxrm_q        <= vxrm;
      src2_signed_q <= src2_signed;
      src1_signed_q <= src1_signed;
      keep_low_q    <= keep_low;
      is_vsmul_q    <= is_vsmul;
    end
  end

endmodule

/* vmul_pkg.sv */
////////////////////
// shared widths, opcode encodings and the lane word for the vector multiply unit
// VLEN is fixed at 128, and element widths are limited to 8, 16 and 32 bits
// funct6 codes are only meaningful together with funct3 (VMULH and VSMUL share a code)
////////////////////

package vmul_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int VLEN      = 128;     // vector register width in bits
  localparam int VLENB     = VLEN / 8;
  localparam int XLEN      = 32;      // scalar operand
  localparam int ROB_TAG_W = 4;
  localparam int NUM_MUL8  = 64;      // 4 columns x 4x4 byte products

  ////////////////////
  // funct3 (RVV encodings)
  ////////////////////
  localparam logic [2:0] OPIVV = 3'd0;
  localparam logic [2:0] OPMVV = 3'd2;
  localparam logic [2:0] OPIVX = 3'd4;
  localparam logic [2:0] OPMVX = 3'd6;

  // funct6 under OPM
  localparam logic [5:0] VMUL    = 6'b100101;
  localparam logic [5:0] VMULH   = 6'b100111;
  localparam logic [5:0] VMULHU  = 6'b100100;
  localparam logic [5:0] VMULHSU = 6'b100110;

  // funct6 under OPI
  localparam logic [5:0] VSMUL   = 6'b100111;

  ////////////////////
  // element width and fixed-point rounding
  ////////////////////
  localparam logic [1:0] EEW8  = 2'd0;
  localparam logic [1:0] EEW16 = 2'd1;
  localparam logic [1:0] EEW32 = 2'd2;

  localparam logic [1:0] RNU = 2'd0;  // round to nearest, ties up
  localparam logic [1:0] RNE = 2'd1;  // round to nearest, ties even
  localparam logic [1:0] RDN = 2'd2;  // truncate
  localparam logic [1:0] ROD = 2'd3;  // round to odd

  ////////////////////
  // one vector register, seen per element width
  ////////////////////
  typedef union packed {
    logic [VLENB-1:0][7:0]    b;    // sixteen bytes
    logic [VLENB/2-1:0][15:0] h;    // eight halfwords
    logic [VLENB/4-1:0][31:0] w;    // four words
  } lane_word_t;

endpackage

/* vmul_unit.f */
vmul_pkg.sv
vmul_operand_decode.sv
vmul_partial_stage.sv
vmul_lane_combine.sv
vmul_unit.sv
tb_vmul_checker.sv
tb_vmul_unit.sv

/* vmul_unit.sv */
////////////////////
// vector integer multiply unit, one micro-op per cycle, one cycle latency
// no back-pressure, results must be taken in their valid cycle
////////////////////

module vmul_unit
  import vmul_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  in_valid,
  input  logic [ROB_TAG_W-1:0]  rob_entry,
  input  logic [5:0]            funct6,
  input  logic [2:0]            funct3,
  input  logic [1:0]            vxrm,
  input  logic [1:0]            eew,
  input  logic [VLEN-1:0]       vs1_data,
  input  logic                  vs1_valid,
  input  logic [VLEN-1:0]       vs2_data,
  input  logic                  vs2_valid,
  input  logic [XLEN-1:0]       rs1_data,
  input  logic                  rs1_valid,
  output logic                  out_valid,
  output logic [ROB_TAG_W-1:0]  out_rob_entry,
  output logic [VLEN-1:0]       out_data,
  output logic [VLENB-1:0]      out_vsat
);

  // decode to multipliers
  logic [VLEN-1:0]           src2;
  logic [VLEN-1:0]           src1;
  logic [VLENB-1:0]          src2_byte_signed;
  logic [VLENB-1:0]          src1_byte_signed;
  logic                      src2_signed;
  logic                      src1_signed;
  logic                      keep_low;
  logic                      is_vsmul;

  // registered stage
  logic [NUM_MUL8-1:0][15:0] prod;
  logic [1:0]                eew_q;
  logic [1:0]                vxrm_q;
  logic                      src2_signed_q;
  logic                      src1_signed_q;
  logic                      keep_low_q;
  logic                      is_vsmul_q;

  vmul_operand_decode u_decode (
    .in_valid         (in_valid),
    .funct6           (funct6),
    .funct3           (funct3),
    .eew              (eew),
    .vs1_data         (vs1_data),
    .vs1_valid        (vs1_valid),
    .vs2_data         (vs2_data),
    .vs2_valid        (vs2_valid),
    .rs1_data         (rs1_data),
    .rs1_valid        (rs1_valid),
    .src2             (src2),
    .src1             (src1),
    .src2_byte_signed (src2_byte_signed),
    .src1_byte_signed (src1_byte_signed),
    .src2_signed      (src2_signed),
    .src1_signed      (src1_signed),
    .keep_low         (keep_low),
    .is_vsmul         (is_vsmul)
  );

  vmul_partial_stage u_partial (
    .clk              (clk),
    .arst_n           (arst_n),
    .in_valid         (in_valid),
    .rob_entry        (rob_entry),
    .eew              (eew),
    .vxrm             (vxrm),
    .src2             (src2),
    .src1             (src1),
    .src2_byte_signed (src2_byte_signed),
    .src1_byte_signed (src1_byte_signed),
    .src2_signed      (src2_signed),
    .src1_signed      (src1_signed),
    .keep_low         (keep_low),
    .is_vsmul         (is_vsmul),
    .prod             (prod),
    .valid_q          (out_valid),      // straight from the register
    .rob_entry_q      (out_rob_entry),
    .eew_q            (eew_q),
    .vxrm_q           (vxrm_q),
    .src2_signed_q    (src2_signed_q),
    .src1_signed_q    (src1_signed_q),
    .keep_low_q       (keep_low_q),
    .is_vsmul_q       (is_vsmul_q)
  );

  vmul_lane_combine u_combine (
    .prod             (prod),
    .eew_q            (eew_q),
    .vxrm_q           (vxrm_q),
    .src2_signed_q    (src2_signed_q),
    .src1_signed_q    (src1_signed_q),
    .keep_low_q       (keep_low_q),
    .is_vsmul_q       (is_vsmul_q),
    .out_data         (out_data),
    .out_vsat         (out_vsat)
  );

endmodule
